// File: logic/odd_pipe_defs.svh
`ifndef ODD_PIPE_DEFS_SVH
`define ODD_PIPE_DEFS_SVH

// datapath widths, bit 0 is the msb everywhere
`define ODD_QUAD_W      128
`define ODD_ADDR_W      7
`define ODD_PC_W        32
`define ODD_I7_W        7
`define ODD_I16_W       16

// packet side fields
`define ODD_LAT_W       4
`define ODD_UID_W       3

// registered stages behind the stage-1 packet
`define ODD_FWD_STAGES  7

// local store limit, applied to every branch target
`define ODD_LSLR        32'h0003_FFFF

// unit latencies in chain positions
`define ODD_PERM_LAT    4
`define ODD_BR_LAT      1

`endif

// File: logic/odd_pipe_pkg.sv
`default_nettype none

`include "odd_pipe_defs.svh"

package odd_pipe_pkg;

    // odd pipe instruction codes, NOP marks an empty issue slot
    typedef enum logic [4:0] {
        // shifts and rotates by bits or bytes
        SHLQBI   = 5'd0,
        SHLQBII  = 5'd1,
        SHLQBY   = 5'd2,
        SHLQBYI  = 5'd3,
        SHLQBYBI = 5'd4,
        ROTQBY   = 5'd5,
        ROTQBYI  = 5'd6,
        ROTQBYBI = 5'd7,
        ROTQBI   = 5'd8,
        ROTQBII  = 5'd9,
        // gather lsb of each element
        GBB      = 5'd10,
        GBH      = 5'd11,
        GB       = 5'd12,
        // branches
        BR       = 5'd13,
        BRA      = 5'd14,
        BRSL     = 5'd15,
        BRASL    = 5'd16,
        BRNZ     = 5'd17,
        BRZ      = 5'd18,
        BRHNZ    = 5'd19,
        BRHZ     = 5'd20,
        NOP      = 5'd31
    } odd_opcode_e;

    // producer of a packet in the forwarding chain
    typedef enum logic [`ODD_UID_W-1:0] {
        NONE    = 3'd0,
        PERMUTE = 3'd5,
        BRANCH  = 3'd7
    } unit_id_e;

endpackage

`default_nettype wire

// File: logic/permute_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "odd_pipe_defs.svh"

module permute_unit (
    input  odd_pipe_pkg::odd_opcode_e opcode,
    input  logic [0:`ODD_QUAD_W-1]    ra,
    input  logic [0:`ODD_QUAD_W-1]    rb,
    input  logic [0:`ODD_I7_W-1]      i7,
    output logic [0:`ODD_QUAD_W-1]    perm_value
);

    // shift amount in bits, byte counts are scaled by 8 here
    logic [0:7] shift_amt;
    logic       rotate;
    logic       do_shift;
    logic [0:31] gathered;
    logic [0:`ODD_QUAD_W-1] fill;
    logic [0:2*`ODD_QUAD_W-1] shifted;

    always_comb
    begin
        shift_amt = '0;
        rotate    = 1'b0;
        do_shift  = 1'b0;
        gathered  = '0;
        case (opcode)
            odd_pipe_pkg::SHLQBI:
            begin
                do_shift  = 1'b1;
                shift_amt = {5'b00000, rb[29:31]};
            end
            odd_pipe_pkg::SHLQBII:
            begin
                do_shift  = 1'b1;
                shift_amt = {5'b00000, i7[4:6]};
            end
            odd_pipe_pkg::SHLQBY:
            begin
                do_shift  = 1'b1;
                shift_amt = {rb[27:31], 3'b000};
            end
            odd_pipe_pkg::SHLQBYI:
            begin
                do_shift  = 1'b1;
                shift_amt = {i7[2:6], 3'b000};
            end
            odd_pipe_pkg::SHLQBYBI:
            begin
                do_shift  = 1'b1;
                shift_amt = {rb[24:28], 3'b000};
            end
            odd_pipe_pkg::ROTQBY:
            begin
                do_shift  = 1'b1;
                rotate    = 1'b1;
                shift_amt = {1'b0, rb[28:31], 3'b000};
            end
            odd_pipe_pkg::ROTQBYI:
            begin
                do_shift  = 1'b1;
                rotate    = 1'b1;
                shift_amt = {1'b0, i7[3:6], 3'b000};
            end
            odd_pipe_pkg::ROTQBYBI:
            begin
                do_shift  = 1'b1;
                rotate    = 1'b1;
                shift_amt = {1'b0, rb[25:28], 3'b000};
            end
            odd_pipe_pkg::ROTQBI:
            begin
                do_shift  = 1'b1;
                rotate    = 1'b1;
                shift_amt = {5'b00000, rb[29:31]};
            end
            odd_pipe_pkg::ROTQBII:
            begin
                do_shift  = 1'b1;
                rotate    = 1'b1;
                shift_amt = {5'b00000, i7[4:6]};
            end
            // element 0 lands leftmost in the right-aligned field
            odd_pipe_pkg::GBB:
            begin
                for (int j = 0; j < 16; j++)
                    gathered[16+j] = ra[8*j+7];
            end
            odd_pipe_pkg::GBH:
            begin
                for (int j = 0; j < 8; j++)
                    gathered[24+j] = ra[16*j+15];
            end
            odd_pipe_pkg::GB:
            begin
                for (int j = 0; j < 4; j++)
                    gathered[28+j] = ra[32*j+31];
            end
            default:
            begin
                do_shift = 1'b0;
            end
        endcase
    end

    // lower half refills from ra for rotates and stays zero for shifts;
    // byte counts past 15 push everything out of the upper half
    assign fill    = rotate ? ra : '0;
    assign shifted = {ra, fill} << shift_amt;

    assign perm_value = do_shift ? shifted[0:`ODD_QUAD_W-1]
                                 : {gathered, {(`ODD_QUAD_W-32){1'b0}}};

endmodule

`default_nettype wire

// File: logic/branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "odd_pipe_defs.svh"

module branch_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  odd_pipe_pkg::odd_opcode_e opcode,
    input  logic [0:`ODD_I16_W-1]     i16,
    input  logic [0:`ODD_PC_W-1]      pc_in,
    input  logic [0:`ODD_QUAD_W-1]    rt_in,
    output logic [0:`ODD_QUAD_W-1]    link_value,
    output logic                      pc_valid,
    output logic [0:`ODD_PC_W-1]      pc_out
);

    logic [0:`ODD_PC_W-1] offset;
    logic [0:`ODD_PC_W-1] seq_pc;
    logic [0:`ODD_PC_W-1] rel_target;
    logic [0:`ODD_PC_W-1] abs_target;
    logic [0:`ODD_PC_W-1] target;
    logic                 word_zero;
    logic                 half_zero;
    logic                 is_branch;

    // word offset, sign-extended
    assign offset = {{(`ODD_PC_W-`ODD_I16_W-2){i16[0]}}, i16, 2'b00};

    assign seq_pc     = (pc_in + `ODD_PC_W'(4)) & `ODD_LSLR;
    assign rel_target = (pc_in + offset) & `ODD_LSLR;
    assign abs_target = offset & `ODD_LSLR;

    assign word_zero = (rt_in[0:31] == 32'd0);
    assign half_zero = (rt_in[16:31] == 16'd0);

    // link word goes to word 0 of rt
    assign link_value = {seq_pc, {(`ODD_QUAD_W-`ODD_PC_W){1'b0}}};

    always_comb
    begin
        is_branch = 1'b1;
        target    = seq_pc;
        case (opcode)
            odd_pipe_pkg::BR,  odd_pipe_pkg::BRSL:  target = rel_target;
            odd_pipe_pkg::BRA, odd_pipe_pkg::BRASL: target = abs_target;
            // conditional forms fall through to pc + 4
            odd_pipe_pkg::BRNZ:  if (!word_zero) target = rel_target;
            odd_pipe_pkg::BRZ:   if (word_zero)  target = rel_target;
            odd_pipe_pkg::BRHNZ: if (!half_zero) target = rel_target;
            odd_pipe_pkg::BRHZ:  if (half_zero)  target = rel_target;
            default: is_branch = 1'b0;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            pc_valid <= 1'b0;
        else
            pc_valid <= is_branch;
    end

    always_ff @(posedge clock)
    begin
        pc_out <= target;
    end

    // an aligned pc from issue must stay aligned through the target math
    assert property (@(posedge clock) disable iff (reset)
        pc_valid |-> (pc_out[`ODD_PC_W-2:`ODD_PC_W-1] == 2'b00));

endmodule

`default_nettype wire

// File: logic/odd_issue.sv
`timescale 1ns/10ps
`default_nettype none

`include "odd_pipe_defs.svh"

module odd_issue (
    input  logic                      clock,
    input  logic                      reset,
    input  odd_pipe_pkg::odd_opcode_e opcode,
    input  logic [0:`ODD_QUAD_W-1]    ra,
    input  logic [0:`ODD_QUAD_W-1]    rb,
    input  logic [0:`ODD_QUAD_W-1]    rt_in,
    input  logic [0:`ODD_ADDR_W-1]    rt_address,
    input  logic [0:`ODD_I7_W-1]      i7,
    input  logic [0:`ODD_I16_W-1]     i16,
    input  logic [0:`ODD_PC_W-1]      pc_in,
    output odd_pipe_pkg::unit_id_e    st_uid,
    output logic [0:`ODD_QUAD_W-1]    st_value,
    output logic                      st_wr_en,
    output logic [0:`ODD_ADDR_W-1]    st_addr,
    output logic [0:`ODD_LAT_W-1]     st_lat,
    output logic                      st_ready,
    output logic                      pc_valid,
    output logic [0:`ODD_PC_W-1]      pc_out
);

    odd_pipe_pkg::odd_opcode_e opcode_r;
    logic [0:`ODD_QUAD_W-1] ra_r;
    logic [0:`ODD_QUAD_W-1] rb_r;
    logic [0:`ODD_QUAD_W-1] rt_in_r;
    logic [0:`ODD_ADDR_W-1] rt_address_r;
    logic [0:`ODD_I7_W-1]   i7_r;
    logic [0:`ODD_I16_W-1]  i16_r;
    logic [0:`ODD_PC_W-1]   pc_r;
    logic [0:`ODD_QUAD_W-1] perm_value;
    logic [0:`ODD_QUAD_W-1] link_value;

    // empty slot after reset
    always_ff @(posedge clock)
    begin
        if (reset)
            opcode_r <= odd_pipe_pkg::NOP;
        else
            opcode_r <= opcode;
    end

    always_ff @(posedge clock)
    begin
        ra_r         <= ra;
        rb_r         <= rb;
        rt_in_r      <= rt_in;
        rt_address_r <= rt_address;
        i7_r         <= i7;
        i16_r        <= i16;
        pc_r         <= pc_in;
    end

    permute_unit u_permute (
        .opcode     (opcode_r),
        .ra         (ra_r),
        .rb         (rb_r),
        .i7         (i7_r),
        .perm_value (perm_value)
    );

    branch_unit u_branch (
        .clock      (clock),
        .reset      (reset),
        .opcode     (opcode_r),
        .i16        (i16_r),
        .pc_in      (pc_r),
        .rt_in      (rt_in_r),
        .link_value (link_value),
        .pc_valid   (pc_valid),
        .pc_out     (pc_out)
    );

    always_comb
    begin
        st_uid   = odd_pipe_pkg::NONE;
        st_value = '0;
        st_wr_en = 1'b0;
        st_lat   = '0;
        case (opcode_r)
            odd_pipe_pkg::SHLQBI,  odd_pipe_pkg::SHLQBII, odd_pipe_pkg::SHLQBY,
            odd_pipe_pkg::SHLQBYI, odd_pipe_pkg::SHLQBYBI,
            odd_pipe_pkg::ROTQBY,  odd_pipe_pkg::ROTQBYI, odd_pipe_pkg::ROTQBYBI,
            odd_pipe_pkg::ROTQBI,  odd_pipe_pkg::ROTQBII,
            odd_pipe_pkg::GBB,     odd_pipe_pkg::GBH,     odd_pipe_pkg::GB:
            begin
                st_uid   = odd_pipe_pkg::PERMUTE;
                st_value = perm_value;
                st_wr_en = 1'b1;
                st_lat   = `ODD_LAT_W'(`ODD_PERM_LAT);
            end
            // only the set-link forms write rt
            odd_pipe_pkg::BRSL, odd_pipe_pkg::BRASL:
            begin
                st_uid   = odd_pipe_pkg::BRANCH;
                st_value = link_value;
                st_wr_en = 1'b1;
                st_lat   = `ODD_LAT_W'(`ODD_BR_LAT);
            end
            odd_pipe_pkg::BR,   odd_pipe_pkg::BRA,
            odd_pipe_pkg::BRNZ, odd_pipe_pkg::BRZ,
            odd_pipe_pkg::BRHNZ, odd_pipe_pkg::BRHZ:
            begin
                st_uid   = odd_pipe_pkg::BRANCH;
                st_value = link_value;
                st_lat   = `ODD_LAT_W'(`ODD_BR_LAT);
            end
            default:
            begin
                st_uid = odd_pipe_pkg::NONE;
            end
        endcase
    end

    assign st_addr = rt_address_r;

    // stage-1 position counts as index 1
    assign st_ready = st_wr_en && (st_lat <= `ODD_LAT_W'(1));

    // a zero latency write would never be flagged ready anywhere in the chain
    assert property (@(posedge clock) disable iff (reset)
        st_wr_en |-> (st_lat != '0));

endmodule

`default_nettype wire

// File: logic/forward_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "odd_pipe_defs.svh"

module forward_stage #(
    parameter int STAGE_INDEX = 2
) (
    input  logic                   clock,
    input  logic                   reset,
    input  odd_pipe_pkg::unit_id_e prev_uid,
    input  logic [0:`ODD_QUAD_W-1] prev_value,
    input  logic                   prev_wr_en,
    input  logic [0:`ODD_ADDR_W-1] prev_addr,
    input  logic [0:`ODD_LAT_W-1]  prev_lat,
    output odd_pipe_pkg::unit_id_e uid,
    output logic [0:`ODD_QUAD_W-1] value,
    output logic                   wr_en,
    output logic [0:`ODD_ADDR_W-1] addr,
    output logic [0:`ODD_LAT_W-1]  lat,
    output logic                   ready
);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            uid   <= odd_pipe_pkg::NONE;
            value <= '0;
            wr_en <= 1'b0;
            addr  <= '0;
            lat   <= '0;
        end
        else
        begin
            uid   <= prev_uid;
            value <= prev_value;
            wr_en <= prev_wr_en;
            addr  <= prev_addr;
            lat   <= prev_lat;
        end
    end

    // result may be forwarded once the unit latency has elapsed
    assign ready = wr_en && (int'(lat) <= STAGE_INDEX);

endmodule

`default_nettype wire

// File: logic/forward_select.sv
`timescale 1ns/10ps
`default_nettype none

`include "odd_pipe_defs.svh"

module forward_select (
    input  logic                   clock,
    input  logic                   reset,
    input  odd_pipe_pkg::unit_id_e uid   [0:`ODD_FWD_STAGES],
    input  logic [0:`ODD_QUAD_W-1] value [0:`ODD_FWD_STAGES],
    input  logic                   wr_en [0:`ODD_FWD_STAGES],
    input  logic [0:`ODD_ADDR_W-1] addr  [0:`ODD_FWD_STAGES],
    input  logic [0:`ODD_LAT_W-1]  lat   [0:`ODD_FWD_STAGES],
    input  logic                   ready [0:`ODD_FWD_STAGES],
    input  logic [0:`ODD_ADDR_W-1] query_address,
    output logic                   fwd_hit,
    output logic [0:`ODD_QUAD_W-1] fwd_value,
    output logic                   rf_wr_en,
    output logic [0:`ODD_ADDR_W-1] rf_addr,
    output logic [0:`ODD_QUAD_W-1] rf_value
);

    // walk from oldest to newest so the newest ready match wins
    always_comb
    begin
        fwd_hit   = 1'b0;
        fwd_value = '0;
        for (int p = `ODD_FWD_STAGES; p >= 0; p--)
        begin
            if (ready[p] && (addr[p] == query_address))
            begin
                fwd_hit   = 1'b1;
                fwd_value = value[p];
            end
        end
    end

    // packet leaving the chain is the register file write
    assign rf_wr_en = wr_en[`ODD_FWD_STAGES];
    assign rf_addr  = addr[`ODD_FWD_STAGES];
    assign rf_value = value[`ODD_FWD_STAGES];

    // writes must carry the unit that produced them all the way down
    assert property (@(posedge clock) disable iff (reset)
        rf_wr_en |-> (uid[`ODD_FWD_STAGES] != odd_pipe_pkg::NONE));

endmodule

`default_nettype wire

// File: logic/odd_pipe.sv
`timescale 1ns/10ps
`default_nettype none

`include "odd_pipe_defs.svh"

module odd_pipe (
    input  logic                      clock,
    input  logic                      reset,
    input  odd_pipe_pkg::odd_opcode_e opcode,
    input  logic [0:`ODD_QUAD_W-1]    ra,
    input  logic [0:`ODD_QUAD_W-1]    rb,
    input  logic [0:`ODD_QUAD_W-1]    rt_in,
    input  logic [0:`ODD_ADDR_W-1]    rt_address,
    input  logic [0:`ODD_I7_W-1]      i7,
    input  logic [0:`ODD_I16_W-1]     i16,
    input  logic [0:`ODD_PC_W-1]      pc_in,
    input  logic [0:`ODD_ADDR_W-1]    query_address,
    output logic                      fwd_hit,
    output logic [0:`ODD_QUAD_W-1]    fwd_value,
    output logic                      rf_wr_en,
    output logic [0:`ODD_ADDR_W-1]    rf_addr,
    output logic [0:`ODD_QUAD_W-1]    rf_value,
    output logic                      pc_valid,
    output logic [0:`ODD_PC_W-1]      pc_out
);

    // position 0 is the stage-1 packet, 1..7 the registered stages
    odd_pipe_pkg::unit_id_e pos_uid   [0:`ODD_FWD_STAGES];
    logic [0:`ODD_QUAD_W-1] pos_value [0:`ODD_FWD_STAGES];
    logic                   pos_wr_en [0:`ODD_FWD_STAGES];
    logic [0:`ODD_ADDR_W-1] pos_addr  [0:`ODD_FWD_STAGES];
    logic [0:`ODD_LAT_W-1]  pos_lat   [0:`ODD_FWD_STAGES];
    logic                   pos_ready [0:`ODD_FWD_STAGES];

    odd_issue u_issue (
        .clock      (clock),
        .reset      (reset),
        .opcode     (opcode),
        .ra         (ra),
        .rb         (rb),
        .rt_in      (rt_in),
        .rt_address (rt_address),
        .i7         (i7),
        .i16        (i16),
        .pc_in      (pc_in),
        .st_uid     (pos_uid[0]),
        .st_value   (pos_value[0]),
        .st_wr_en   (pos_wr_en[0]),
        .st_addr    (pos_addr[0]),
        .st_lat     (pos_lat[0]),
        .st_ready   (pos_ready[0]),
        .pc_valid   (pc_valid),
        .pc_out     (pc_out)
    );

    for (genvar g = 0; g < `ODD_FWD_STAGES; g++)
    begin : g_stage
        forward_stage #(
            .STAGE_INDEX (g + 2)
        ) u_stage (
            .clock      (clock),
            .reset      (reset),
            .prev_uid   (pos_uid[g]),
            .prev_value (pos_value[g]),
            .prev_wr_en (pos_wr_en[g]),
            .prev_addr  (pos_addr[g]),
            .prev_lat   (pos_lat[g]),
            .uid        (pos_uid[g+1]),
            .value      (pos_value[g+1]),
            .wr_en      (pos_wr_en[g+1]),
            .addr       (pos_addr[g+1]),
            .lat        (pos_lat[g+1]),
            .ready      (pos_ready[g+1])
        );
    end

    forward_select u_select (
        .clock         (clock),
        .reset         (reset),
        .uid           (pos_uid),
        .value         (pos_value),
        .wr_en         (pos_wr_en),
        .addr          (pos_addr),
        .lat           (pos_lat),
        .ready         (pos_ready),
        .query_address (query_address),
        .fwd_hit       (fwd_hit),
        .fwd_value     (fwd_value),
        .rf_wr_en      (rf_wr_en),
        .rf_addr       (rf_addr),
        .rf_value      (rf_value)
    );

endmodule

`default_nettype wire

// File: dv/odd_pipe_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "odd_pipe_defs.svh"

module odd_pipe_tb;

    localparam int CLOCK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 8;
    localparam int MAX_ROWS     = 32;
    localparam logic [31:0] LFSR_SEED = 32'h54b3_7d96;

    // operand patterns for the hand-computed shift and gather rows
    localparam logic [0:`ODD_QUAD_W-1] QUAD_A = 128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff;
    localparam logic [0:`ODD_QUAD_W-1] QUAD_B = 128'hfffe_0001_0003_0002_0000_ffff_1234_5678;

    logic                      clock;
    logic                      reset;
    odd_pipe_pkg::odd_opcode_e opcode;
    logic [0:`ODD_QUAD_W-1]    ra;
    logic [0:`ODD_QUAD_W-1]    rb;
    logic [0:`ODD_QUAD_W-1]    rt_in;
    logic [0:`ODD_ADDR_W-1]    rt_address;
    logic [0:`ODD_I7_W-1]      i7;
    logic [0:`ODD_I16_W-1]     i16;
    logic [0:`ODD_PC_W-1]      pc_in;
    logic [0:`ODD_ADDR_W-1]    query_address;
    logic                      fwd_hit;
    logic [0:`ODD_QUAD_W-1]    fwd_value;
    logic                      rf_wr_en;
    logic [0:`ODD_ADDR_W-1]    rf_addr;
    logic [0:`ODD_QUAD_W-1]    rf_value;
    logic                      pc_valid;
    logic [0:`ODD_PC_W-1]      pc_out;

    // stimulus and expected results with one row per issue slot
    odd_pipe_pkg::odd_opcode_e tbl_op        [0:MAX_ROWS-1];
    logic [0:`ODD_QUAD_W-1]    tbl_ra        [0:MAX_ROWS-1];
    logic [0:`ODD_QUAD_W-1]    tbl_rb        [0:MAX_ROWS-1];
    logic [0:`ODD_QUAD_W-1]    tbl_rt        [0:MAX_ROWS-1];
    logic [0:`ODD_I7_W-1]      tbl_i7        [0:MAX_ROWS-1];
    logic [0:`ODD_I16_W-1]     tbl_i16       [0:MAX_ROWS-1];
    logic [0:`ODD_PC_W-1]      tbl_pc        [0:MAX_ROWS-1];
    logic [0:`ODD_ADDR_W-1]    tbl_addr      [0:MAX_ROWS-1];
    logic [0:`ODD_ADDR_W-1]    tbl_query     [0:MAX_ROWS-1];
    logic [0:`ODD_QUAD_W-1]    tbl_exp_value [0:MAX_ROWS-1];
    logic                      tbl_exp_wr    [0:MAX_ROWS-1];
    logic [0:`ODD_PC_W-1]      tbl_exp_pc    [0:MAX_ROWS-1];

    int          num_rows;
    int          check_count;
    int          error_count;
    logic        table_ready;
    logic [31:0] lfsr_state;
    logic [0:`ODD_QUAD_W-1] rnd;

    odd_pipe DUT (
        .clock         (clock),
        .reset         (reset),
        .opcode        (opcode),
        .ra            (ra),
        .rb            (rb),
        .rt_in         (rt_in),
        .rt_address    (rt_address),
        .i7            (i7),
        .i16           (i16),
        .pc_in         (pc_in),
        .query_address (query_address),
        .fwd_hit       (fwd_hit),
        .fwd_value     (fwd_value),
        .rf_wr_en      (rf_wr_en),
        .rf_addr       (rf_addr),
        .rf_value      (rf_value),
        .pc_valid      (pc_valid),
        .pc_out        (pc_out)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_quad(output logic [0:`ODD_QUAD_W-1] q);
        for (int i = 0; i < `ODD_QUAD_W; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            q[i] = lfsr_state[0];
        end
    endtask

    // bits leaving bit 0 come back in at bit 127
    function automatic logic [0:`ODD_QUAD_W-1] rotate_left(input logic [0:`ODD_QUAD_W-1] v,
                                                           input int n);
        int k;
        k = n % `ODD_QUAD_W;
        if (k == 0)
            return v;
        return (v << k) | (v >> (`ODD_QUAD_W - k));
    endfunction

    task automatic perm_row(input odd_pipe_pkg::odd_opcode_e op,
                            input logic [0:`ODD_QUAD_W-1] a, input logic [0:31] rb_word,
                            input logic [0:`ODD_I7_W-1] imm, input logic [0:`ODD_ADDR_W-1] addr,
                            input logic [0:`ODD_ADDR_W-1] query,
                            input logic [0:`ODD_QUAD_W-1] exp_value);
        tbl_op[num_rows]        = op;
        tbl_ra[num_rows]        = a;
        tbl_rb[num_rows]        = {rb_word, 96'h0};
        tbl_rt[num_rows]        = '0;
        tbl_i7[num_rows]        = imm;
        tbl_i16[num_rows]       = '0;
        tbl_pc[num_rows]        = '0;
        tbl_addr[num_rows]      = addr;
        tbl_query[num_rows]     = query;
        tbl_exp_value[num_rows] = exp_value;
        tbl_exp_wr[num_rows]    = (op != odd_pipe_pkg::NOP);
        tbl_exp_pc[num_rows]    = '0;
        num_rows++;
    endtask

    task automatic branch_row(input odd_pipe_pkg::odd_opcode_e op, input logic [0:31] rt_word,
                              input logic [0:`ODD_I16_W-1] imm16, input logic [0:`ODD_PC_W-1] pc,
                              input logic [0:`ODD_ADDR_W-1] addr,
                              input logic [0:`ODD_ADDR_W-1] query,
                              input logic [0:`ODD_PC_W-1] exp_pc, input logic wr,
                              input logic [0:31] link_word);
        tbl_op[num_rows]        = op;
        tbl_ra[num_rows]        = '0;
        tbl_rb[num_rows]        = '0;
        tbl_rt[num_rows]        = {rt_word, 96'h0};
        tbl_i7[num_rows]        = '0;
        tbl_i16[num_rows]       = imm16;
        tbl_pc[num_rows]        = pc;
        tbl_addr[num_rows]      = addr;
        tbl_query[num_rows]     = query;
        tbl_exp_value[num_rows] = {link_word, 96'h0};
        tbl_exp_wr[num_rows]    = wr;
        tbl_exp_pc[num_rows]    = exp_pc;
        num_rows++;
    endtask

    task automatic fill_table();
        // shifts; rows 0 and 1 both write r20 so the newer one must win
        perm_row(odd_pipe_pkg::SHLQBY, QUAD_A, 32'h3, 7'd0, 7'd20, 7'd127,
                 128'h3344_5566_7788_99aa_bbcc_ddee_ff00_0000);
        perm_row(odd_pipe_pkg::SHLQBYI, QUAD_A, 32'h0, 7'd5, 7'd20, 7'd20,
                 128'h5566_7788_99aa_bbcc_ddee_ff00_0000_0000);
        perm_row(odd_pipe_pkg::SHLQBY, QUAD_A, 32'h10, 7'd0, 7'd21, 7'd20, '0);
        perm_row(odd_pipe_pkg::SHLQBYI, QUAD_A, 32'h0, 7'd20, 7'd22, 7'd20, '0);
        perm_row(odd_pipe_pkg::SHLQBYBI, QUAD_A, 32'h10, 7'd0, 7'd23, 7'd20,
                 128'h2233_4455_6677_8899_aabb_ccdd_eeff_0000);
        perm_row(odd_pipe_pkg::SHLQBI, QUAD_A, 32'h4, 7'd0, 7'd24, 7'd20,
                 128'h0112_2334_4556_6778_899a_abbc_cdde_eff0);
        perm_row(odd_pipe_pkg::SHLQBII, QUAD_A, 32'h0, 7'd1, 7'd25, 7'd21,
                 128'h0022_4466_88aa_ccef_1133_5577_99bb_ddfe);
        // rotates on random operands
        random_quad(rnd);
        perm_row(odd_pipe_pkg::ROTQBY, rnd, 32'h5, 7'd0, 7'd30, 7'd20, rotate_left(rnd, 40));
        random_quad(rnd);
        perm_row(odd_pipe_pkg::ROTQBYI, rnd, 32'h0, 7'd11, 7'd31, 7'd20, rotate_left(rnd, 88));
        random_quad(rnd);
        perm_row(odd_pipe_pkg::ROTQBYBI, rnd, 32'h48, 7'd0, 7'd32, 7'd127, rotate_left(rnd, 72));
        random_quad(rnd);
        perm_row(odd_pipe_pkg::ROTQBI, rnd, 32'h3, 7'd0, 7'd33, 7'd30, rotate_left(rnd, 3));
        random_quad(rnd);
        perm_row(odd_pipe_pkg::ROTQBII, rnd, 32'h0, 7'd6, 7'd34, 7'd30, rotate_left(rnd, 6));
        // gathers
        perm_row(odd_pipe_pkg::GBB, QUAD_B, 32'h0, 7'd0, 7'd40, 7'd127, {32'h9430, 96'h0});
        perm_row(odd_pipe_pkg::GBH, QUAD_B, 32'h0, 7'd0, 7'd41, 7'd127, {32'h64, 96'h0});
        perm_row(odd_pipe_pkg::GB, QUAD_B, 32'h0, 7'd0, 7'd42, 7'd127, {32'ha, 96'h0});
        perm_row(odd_pipe_pkg::NOP, '0, 32'h0, 7'd0, 7'd40, 7'd40, '0);
        // unconditional branches and set-link forms
        branch_row(odd_pipe_pkg::BR, 32'h0, 16'h0010, 32'h1000, 7'd40, 7'd40, 32'h1040, 1'b0, 32'h0);
        branch_row(odd_pipe_pkg::BR, 32'h0, 16'hfffc, 32'h1000, 7'd50, 7'd127, 32'h0ff0, 1'b0, 32'h0);
        branch_row(odd_pipe_pkg::BRA, 32'h0, 16'h0100, 32'h1000, 7'd50, 7'd127, 32'h400, 1'b0, 32'h0);
        branch_row(odd_pipe_pkg::BRA, 32'h0, 16'h8000, 32'h1000, 7'd50, 7'd127, 32'h20000, 1'b0,
                   32'h0);
        branch_row(odd_pipe_pkg::BRSL, 32'h0, 16'h0020, 32'h2000, 7'd12, 7'd127, 32'h2080, 1'b1,
                   32'h2004);
        branch_row(odd_pipe_pkg::BRASL, 32'h0, 16'h0008, 32'h3fffc, 7'd13, 7'd12, 32'h20, 1'b1,
                   32'h0);
        // conditional branches taken and falling through
        branch_row(odd_pipe_pkg::BRZ, 32'h0, 16'h0010, 32'h500, 7'd50, 7'd13, 32'h540, 1'b0, 32'h0);
        branch_row(odd_pipe_pkg::BRZ, 32'h1, 16'h0010, 32'h500, 7'd50, 7'd127, 32'h504, 1'b0, 32'h0);
        branch_row(odd_pipe_pkg::BRNZ, 32'h8000_0000, 16'h0010, 32'h600, 7'd50, 7'd127, 32'h640,
                   1'b0, 32'h0);
        branch_row(odd_pipe_pkg::BRNZ, 32'h0, 16'h0010, 32'h600, 7'd50, 7'd127, 32'h604, 1'b0, 32'h0);
        branch_row(odd_pipe_pkg::BRHZ, 32'hffff_0000, 16'h0010, 32'h700, 7'd50, 7'd127, 32'h740,
                   1'b0, 32'h0);
        branch_row(odd_pipe_pkg::BRHNZ, 32'hffff_0000, 16'h0010, 32'h700, 7'd50, 7'd127, 32'h704,
                   1'b0, 32'h0);
        branch_row(odd_pipe_pkg::BRHNZ, 32'h1, 16'h0010, 32'h700, 7'd50, 7'd127, 32'h740, 1'b0,
                   32'h0);
        branch_row(odd_pipe_pkg::BRHZ, 32'h100, 16'h0010, 32'h700, 7'd50, 7'd127, 32'h704, 1'b0,
                   32'h0);
        // r12 link has left the chain by now
        perm_row(odd_pipe_pkg::NOP, '0, 32'h0, 7'd0, 7'd0, 7'd12, '0);
    endtask

    function automatic logic row_is_branch(input int idx);
        logic is_br;
        if (idx < 0 || idx >= num_rows)
            return 1'b0;
        case (tbl_op[idx])
            odd_pipe_pkg::BR,   odd_pipe_pkg::BRA,  odd_pipe_pkg::BRSL,  odd_pipe_pkg::BRASL,
            odd_pipe_pkg::BRNZ, odd_pipe_pkg::BRZ,  odd_pipe_pkg::BRHNZ, odd_pipe_pkg::BRHZ:
                is_br = 1'b1;
            default:
                is_br = 1'b0;
        endcase
        return is_br;
    endfunction

    function automatic logic row_writes(input int idx);
        if (idx < 0 || idx >= num_rows)
            return 1'b0;
        return tbl_exp_wr[idx];
    endfunction

    // newest in-flight write whose unit latency has elapsed
    task automatic expected_forward(input int n, input logic [0:`ODD_ADDR_W-1] q,
                                    output logic hit, output logic [0:`ODD_QUAD_W-1] val);
        int lat;
        hit = 1'b0;
        val = '0;
        for (int m = n - DRAIN_CYCLES; m < n; m++)
        begin
            lat = row_is_branch(m) ? `ODD_BR_LAT : `ODD_PERM_LAT;
            if (row_writes(m))
            begin
                if (tbl_addr[m] == q && (n - m) >= lat)
                begin
                    hit = 1'b1;
                    val = tbl_exp_value[m];
                end
            end
        end
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic drive_idle();
        opcode        = odd_pipe_pkg::NOP;
        ra            = '0;
        rb            = '0;
        rt_in         = '0;
        rt_address    = '0;
        i7            = '0;
        i16           = '0;
        pc_in         = '0;
        query_address = '0;
    endtask

    task automatic drive_row(input int idx);
        if (idx >= num_rows)
        begin
            drive_idle();
            query_address = 7'd127;
        end
        else
        begin
            opcode        = tbl_op[idx];
            ra            = tbl_ra[idx];
            rb            = tbl_rb[idx];
            rt_in         = tbl_rt[idx];
            rt_address    = tbl_addr[idx];
            i7            = tbl_i7[idx];
            i16           = tbl_i16[idx];
            pc_in         = tbl_pc[idx];
            query_address = tbl_query[idx];
        end
    endtask

    // row n is on the inputs; pc belongs to row n-2, the register write to row n-8
    task automatic check_outputs(input int n);
        logic                   exp_hit;
        logic [0:`ODD_QUAD_W-1] exp_fwd;
        int                     p;
        expected_forward(n, query_address, exp_hit, exp_fwd);
        check_value("fwd_hit", 128'(fwd_hit), 128'(exp_hit));
        if (exp_hit)
            check_value("fwd_value", fwd_value, exp_fwd);
        p = n - 2;
        check_value("pc_valid", 128'(pc_valid), 128'(row_is_branch(p)));
        if (row_is_branch(p))
            check_value("pc_out", 128'(pc_out), 128'(tbl_exp_pc[p]));
        p = n - DRAIN_CYCLES;
        check_value("rf_wr_en", 128'(rf_wr_en), 128'(row_writes(p)));
        if (row_writes(p))
        begin
            check_value("rf_addr", 128'(rf_addr), 128'(tbl_addr[p]));
            check_value("rf_value", rf_value, tbl_exp_value[p]);
        end
    endtask

    initial
    begin
        clock       = 1'b0;
        reset       = 1'b1;
        check_count = 0;
        error_count = 0;
        num_rows    = 0;
        table_ready = 1'b0;
        lfsr_state  = LFSR_SEED;
        drive_idle();
        // a set-link write to r0 waits on the inputs for the whole reset
        opcode      = odd_pipe_pkg::BRSL;
        pc_in       = 32'h100;
        fill_table();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        drive_idle();

        // nothing sampled during reset may show up as a branch, a write or a hit on r0
        @(negedge clock);
        #1;
        check_value("rf_wr_en", 128'(rf_wr_en), 128'(0));
        check_value("pc_valid", 128'(pc_valid), 128'(0));
        check_value("fwd_hit", 128'(fwd_hit), 128'(0));

        for (int n = 0; n < num_rows + DRAIN_CYCLES; n++)
        begin
            @(negedge clock);
            drive_row(n);
            #1;
            check_outputs(n);
        end

        $display("Checks run: %0d, mismatches: %0d", check_count, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin
        wait (table_ready);
        #((RESET_CYCLES + num_rows + DRAIN_CYCLES + 50) * CLOCK_PERIOD);
        $display("Watchdog timeout, the table run did not complete in time");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/odd_pipe_pkg.sv
logic/permute_unit.sv
logic/branch_unit.sv
logic/odd_issue.sv
logic/forward_stage.sv
logic/forward_select.sv
logic/odd_pipe.sv
dv/odd_pipe_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := odd_pipe_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard logic/*.sv logic/*.svh dv/*.sv)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# passes only if the simulation printed the pass line
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)
